// ==== build.f ====
logic/fifo_pkg.sv
logic/syncfifo.sv
logic/chaos_lfsr.sv
logic/fifo_regs.sv
logic/fifo_stage.sv
verification/fifo_stage_chk.sv
verification/fifo_stage_tb.sv

// ==== logic/chaos_lfsr.sv ====
`timescale 1ns/10ps

module chaos_lfsr
  (
   input  logic                clk,
   input  logic                nreset,
   input  fifo_pkg::chaos_cfg_t cfg,         // enable, seed, load strobe
   output logic                chaos_full    // forced full request
   );

   import fifo_pkg::*;

   lfsr_t state;       // current lfsr value
   lfsr_t next_state;  // one galois step ahead

   //####################################################################
   // galois step
   //####################################################################

   always_comb
   begin
      next_state = {1'b0, state[15:1]};     // shift right
      if (state[0])
      begin
         next_state = next_state ^ LFSR_TAPS; // feedback from bit leaving
      end
   end

   //####################################################################
   // state register
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state <= lfsr_t'(1);                // nonzero start
      end
      else if (cfg.seed_load)
      begin
         state <= cfg.seed;                  // load replaces the step
      end
      else
      begin
         state <= next_state;                // free running
      end
   end

   // low bit drives the forced full, only while enabled
   assign chaos_full = cfg.enable & state[0];

endmodule

// ==== logic/fifo_pkg.sv ====
package fifo_pkg;

   //####################################################################
   // fifo geometry
   //####################################################################

   localparam int DEPTH = 8;               // fifo entries
   localparam int AW    = $clog2(DEPTH);   // memory address bits

   typedef logic [31:0] data_t;            // one fifo word
   typedef logic [AW:0] ptr_t;             // address plus wrap bit
   typedef logic [AW:0] level_t;           // fill level, 0..DEPTH

   //####################################################################
   // chaos generator
   //####################################################################

   typedef logic [15:0] lfsr_t;

   // galois taps, shifted in on a one leaving bit 0
   localparam lfsr_t LFSR_TAPS = 16'hB400;

   //####################################################################
   // register map
   //####################################################################

   typedef logic [2:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   localparam reg_addr_t REG_CTRL   = 3'd0;   // bit 0 chaos enable
   localparam reg_addr_t REG_SEED   = 3'd1;   // lfsr seed, low 16 bits
   localparam reg_addr_t REG_WCOUNT = 3'd2;   // accepted writes
   localparam reg_addr_t REG_RCOUNT = 3'd3;   // accepted reads
   localparam reg_addr_t REG_DROPS  = 3'd4;   // refused writes
   localparam reg_addr_t REG_LEVEL  = 3'd5;   // live fill level

   //####################################################################
   // shared structs
   //####################################################################

   // fifo -> register block, pulses line up with the accepting edge
   typedef struct packed {
      logic   wr_event;      // write accepted
      logic   rd_event;      // read accepted
      logic   drop_event;    // write refused
      level_t level;         // current fill
   } fifo_status_t;

   // register block -> lfsr
   typedef struct packed {
      logic  enable;         // gate on chaos_full
      logic  seed_load;      // one cycle load strobe
      lfsr_t seed;           // never zero
   } chaos_cfg_t;

endpackage

// ==== logic/fifo_regs.sv ====
`timescale 1ns/10ps

module fifo_regs
  (
   input  logic                   clk,
   input  logic                   nreset,
   // register port
   input  logic                   reg_wr,      // write strobe
   input  logic                   reg_rd,      // read strobe
   input  fifo_pkg::reg_addr_t    reg_addr,
   input  fifo_pkg::reg_data_t    reg_wdata,
   output fifo_pkg::reg_data_t    reg_rdata,   // valid the cycle after reg_rd
   // fifo side
   input  fifo_pkg::fifo_status_t status,      // events and level
   output fifo_pkg::chaos_cfg_t   cfg          // to chaos lfsr
   );

   import fifo_pkg::*;

   logic      chaos_en;     // REG_CTRL bit 0
   lfsr_t     seed;         // REG_SEED
   logic      seed_load;    // pulse after a seed write
   reg_data_t wcount;       // accepted writes
   reg_data_t rcount;       // accepted reads
   reg_data_t drops;        // refused writes
   reg_data_t rd_mux;       // readback select
   lfsr_t     wr_seed;      // seed as written, zero fixed up

   //####################################################################
   // control and seed
   //####################################################################

   // an all zero seed would lock the lfsr
   assign wr_seed = (reg_wdata[15:0] == 16'h0000) ? lfsr_t'(1) : reg_wdata[15:0];

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         chaos_en  <= 1'b0;
         seed      <= lfsr_t'(1);
         seed_load <= 1'b0;
      end
      else
      begin
         seed_load <= 1'b0;                  // default, one cycle only
         if (reg_wr && (reg_addr == REG_CTRL))
         begin
            chaos_en <= reg_wdata[0];
         end
         if (reg_wr && (reg_addr == REG_SEED))
         begin
            seed      <= wr_seed;
            seed_load <= 1'b1;               // lfsr picks it up next edge
         end
      end
   end

   assign cfg = '{enable: chaos_en, seed_load: seed_load, seed: seed};

   //####################################################################
   // statistics, free wrapping
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wcount <= '0;
         rcount <= '0;
         drops  <= '0;
      end
      else
      begin
         wcount <= wcount + reg_data_t'(status.wr_event);
         rcount <= rcount + reg_data_t'(status.rd_event);
         drops  <= drops + reg_data_t'(status.drop_event);
      end
   end

   //####################################################################
   // readback
   //####################################################################

   always_comb
   begin
      case (reg_addr)
         REG_CTRL   : rd_mux = reg_data_t'(chaos_en);
         REG_SEED   : rd_mux = reg_data_t'(seed);
         REG_WCOUNT : rd_mux = wcount;
         REG_RCOUNT : rd_mux = rcount;
         REG_DROPS  : rd_mux = drops;
         REG_LEVEL  : rd_mux = reg_data_t'(status.level);  // zero extended
         default    : rd_mux = '0;                         // unmapped
      endcase
   end

   // held until the next read
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         reg_rdata <= '0;
      end
      else if (reg_rd)
      begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

// ==== logic/fifo_stage.sv ====
`timescale 1ns/10ps

module fifo_stage
  (
   input  logic                clk,
   input  logic                nreset,
   // producer
   input  logic                wr_en,
   input  fifo_pkg::data_t     wr_din,
   output logic                wr_full,
   // consumer
   input  logic                rd_en,
   output fifo_pkg::data_t     rd_dout,
   output logic                rd_empty,
   // register port
   input  logic                reg_wr,
   input  logic                reg_rd,
   input  fifo_pkg::reg_addr_t reg_addr,
   input  fifo_pkg::reg_data_t reg_wdata,
   output fifo_pkg::reg_data_t reg_rdata
   );

   import fifo_pkg::*;

   fifo_status_t status;      // fifo -> regs
   chaos_cfg_t   cfg;         // regs -> lfsr
   logic         chaos_full;  // lfsr -> fifo

   //####################################################################
   // datapath
   //####################################################################

   syncfifo u_fifo
     (.clk        (clk),
      .nreset     (nreset),
      .wr_en      (wr_en),
      .wr_din     (wr_din),
      .wr_full    (wr_full),
      .rd_en      (rd_en),
      .rd_dout    (rd_dout),
      .rd_empty   (rd_empty),
      .chaos_full (chaos_full),
      .status     (status));

   //####################################################################
   // back-pressure generator and registers
   //####################################################################

   chaos_lfsr u_lfsr
     (.clk        (clk),
      .nreset     (nreset),
      .cfg        (cfg),
      .chaos_full (chaos_full));

   fifo_regs u_regs
     (.clk        (clk),
      .nreset     (nreset),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .status     (status),
      .cfg        (cfg));

endmodule

// ==== logic/syncfifo.sv ====
`timescale 1ns/10ps

module syncfifo
  (
   input  logic                  clk,
   input  logic                  nreset,
   // write side
   input  logic                  wr_en,       // write strobe
   input  fifo_pkg::data_t       wr_din,      // word to push
   output logic                  wr_full,     // back-pressure level
   // read side
   input  logic                  rd_en,       // read strobe
   output fifo_pkg::data_t       rd_dout,     // head word, fall-through
   output logic                  rd_empty,    // nothing to read
   // chaos and status
   input  logic                  chaos_full,  // forced full from lfsr
   output fifo_pkg::fifo_status_t status      // events and level
   );

   import fifo_pkg::*;

   ptr_t  wr_ptr;         // next slot to write
   ptr_t  rd_ptr;         // head slot
   logic  ptr_full;       // full from pointer compare only
   logic  fifo_write;     // write accepted this cycle
   logic  fifo_read;      // read accepted this cycle
   data_t mem [DEPTH];    // storage

   //####################################################################
   // flags
   //####################################################################

   // same slot, opposite lap
   assign ptr_full = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign rd_empty = (wr_ptr == rd_ptr);     // pointers equal incl wrap bit

   // chaos can pull full high at any cycle
   assign wr_full  = ptr_full | chaos_full;

   assign fifo_write = wr_en & ~wr_full;     // refused when full
   assign fifo_read  = rd_en & ~rd_empty;    // ignored when empty

   //####################################################################
   // pointers
   //####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (fifo_write)
         begin
            wr_ptr <= wr_ptr + ptr_t'(1);    // wraps through the lap bit
         end
         if (fifo_read)
         begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
      end
   end

   //####################################################################
   // memory
   //####################################################################

   // write port
   always_ff @(posedge clk)
   begin
      if (fifo_write)
      begin
         mem[wr_ptr[AW-1:0]] <= wr_din;
      end
   end

   // read port, combinational head of queue
   assign rd_dout = mem[rd_ptr[AW-1:0]];

   //####################################################################
   // status to register block
   //####################################################################

   always_comb
   begin
      status.wr_event   = fifo_write;
      status.rd_event   = fifo_read;
      status.drop_event = wr_en & wr_full;   // drop, chaos or real full
      // same width as the pointers, so the wrap cancels out
      status.level      = level_t'(wr_ptr - rd_ptr);
   end

endmodule

// ==== verification/fifo_stage_chk.sv ====
`timescale 1ns/10ps

module fifo_stage_chk
  (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   wr_en,       // write strobe
   input  logic                   rd_en,       // read strobe
   input  logic                   wr_full,     // pointer or chaos full
   input  logic                   rd_empty,
   input  logic                   ptr_full,    // full from pointers alone
   input  fifo_pkg::ptr_t         wr_ptr,
   input  fifo_pkg::ptr_t         rd_ptr,
   input  fifo_pkg::fifo_status_t status
   );

   import fifo_pkg::*;

   // chaos can raise wr_full on an empty fifo
   a_full_empty : assert property (@(posedge clk) disable iff (!nreset)
                                   !(ptr_full && rd_empty))
      else $error("pointer full and empty at the same time");

   a_level_max : assert property (@(posedge clk) disable iff (!nreset)
                                  status.level <= level_t'(DEPTH))
      else $error("fill level above depth: %0d", status.level);

   // refused write leaves the write pointer alone
   a_wr_hold : assert property (@(posedge clk) disable iff (!nreset)
                                (wr_en && wr_full) |=> $stable(wr_ptr))
      else $error("write pointer moved on a refused write");

   a_rd_hold : assert property (@(posedge clk) disable iff (!nreset)
                                (rd_en && rd_empty) |=> $stable(rd_ptr))
      else $error("read pointer moved on a read while empty");

endmodule

// ==== verification/fifo_stage_tb.sv ====
`timescale 1ns/10ps

module fifo_stage_tb;

   import fifo_pkg::*;

   localparam int          RAND_CYCLES = 300;        // chaos traffic length
   localparam logic [15:0] RNG_SEED    = 16'd42567;
   localparam logic [15:0] RNG_TAPS    = 16'hB400;   // galois mask of tb rng

   localparam logic [2:0] OP_WR    = 3'd0;
   localparam logic [2:0] OP_RD    = 3'd1;
   localparam logic [2:0] OP_BOTH  = 3'd2;
   localparam logic [2:0] OP_IDLE  = 3'd3;
   localparam logic [2:0] OP_REGWR = 3'd4;
   localparam logic [2:0] OP_REGRD = 3'd5;

   typedef struct packed {
      logic [2:0] op;
      reg_addr_t  addr;    // register ops only
      reg_data_t  arg;     // write data or register data
      reg_data_t  exp;     // register read result
   } row_t;

   logic      clk;
   logic      nreset;
   logic      wr_en;
   data_t     wr_din;
   logic      wr_full;
   logic      rd_en;
   data_t     rd_dout;
   logic      rd_empty;
   logic      reg_wr;
   logic      reg_rd;
   reg_addr_t reg_addr;
   reg_data_t reg_wdata;
   reg_data_t reg_rdata;

   row_t        stim_q[$];       // stimulus table
   data_t       ref_q[$];        // reference fifo
   reg_data_t   wcount_m;        // model counters
   reg_data_t   rcount_m;
   reg_data_t   drops_m;
   logic        chaos_m;         // chaos enable as written
   logic        pend_rd;         // register read waiting for its data
   reg_addr_t   pend_addr;
   reg_data_t   pend_exp;
   int          data_errs;
   int          flag_errs;
   int          reg_errs;
   int          other_errs;
   int          toggles;         // wr_full edges seen
   int          forced;          // full without a full queue
   logic        last_full;
   logic [15:0] rng_state;
   int          cycle_cnt;
   int          timeout_limit = 100000;   // replaced once the table is built

   fifo_stage UUT
     (.clk(clk), .nreset(nreset),
      .wr_en(wr_en), .wr_din(wr_din), .wr_full(wr_full),
      .rd_en(rd_en), .rd_dout(rd_dout), .rd_empty(rd_empty),
      .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
      .reg_wdata(reg_wdata), .reg_rdata(reg_rdata));

   bind syncfifo fifo_stage_chk u_chk
     (.clk(clk), .nreset(nreset), .wr_en(wr_en), .rd_en(rd_en),
      .wr_full(wr_full), .rd_empty(rd_empty), .ptr_full(ptr_full),
      .wr_ptr(wr_ptr), .rd_ptr(rd_ptr), .status(status));

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;      // 8 ns period
   end

   //####################################################################
   // random source
   //####################################################################

   function logic rand_bit();
      logic lsb;
      lsb       = rng_state[0];
      rng_state = rng_state >> 1;
      if (lsb)
      begin
         rng_state = rng_state ^ RNG_TAPS;
      end
      return lsb;
   endfunction

   function reg_data_t rand_word();
      reg_data_t w;
      int        i;
      w = '0;
      for (i = 0; i < 32; i++)
      begin
         w = {w[30:0], rand_bit()};     // one step per bit
      end
      return w;
   endfunction

   //####################################################################
   // one cycle of stimulus with model update and checks
   //####################################################################

   task automatic step(input logic w, input data_t d, input logic r, input logic rw,
                       input logic rr, input reg_addr_t addr, input reg_data_t wdata,
                       input reg_data_t exp);
      logic  wr_ok;
      logic  rd_ok;
      data_t head;
      @(negedge clk);
      if (pend_rd)                      // data from last cycle's reg_rd
      begin
         assert (reg_rdata == pend_exp)
         else
         begin
            $display("FAILED reg_rdata at addr %h: expected %h, got %h",
                     pend_addr, pend_exp, reg_rdata);
            reg_errs++;
         end
      end
      assert (rd_empty == (ref_q.size() == 0))
      else
      begin
         $display("FAILED rd_empty: expected %h, got %h", ref_q.size() == 0, rd_empty);
         flag_errs++;
      end
      if (!chaos_m)
      begin
         assert (wr_full == (ref_q.size() == DEPTH))
         else
         begin
            $display("FAILED wr_full: expected %h, got %h", ref_q.size() == DEPTH, wr_full);
            flag_errs++;
         end
      end
      else if (ref_q.size() == DEPTH)
      begin
         assert (wr_full)
         else
         begin
            $display("FAILED wr_full: expected %h, got %h", 1'b1, wr_full);
            flag_errs++;
         end
      end
      if (wr_full && (ref_q.size() < DEPTH)) forced++;   // chaos at work
      if (wr_full != last_full) toggles++;
      last_full = wr_full;
      // acceptance at the coming edge follows the flags as they stand now
      wr_ok = w & ~wr_full;
      rd_ok = r & ~rd_empty;
      if (rd_ok && (ref_q.size() == 0))
      begin
         $display("read accepted although the reference queue is empty");
         other_errs++;
      end
      else if (rd_ok)
      begin
         head = ref_q.pop_front();
         assert (rd_dout == head)
         else
         begin
            $display("FAILED rd_dout: expected %h, got %h", head, rd_dout);
            data_errs++;
         end
      end
      if (rd_ok) rcount_m++;
      if (wr_ok)
      begin
         ref_q.push_back(d);
         wcount_m++;
      end
      if (w && wr_full) drops_m++;      // refused write
      wr_en     = w;
      wr_din    = d;
      rd_en     = r;
      reg_wr    = rw;
      reg_rd    = rr;
      reg_addr  = addr;
      reg_wdata = wdata;
      pend_rd   = rr;
      pend_addr = addr;
      pend_exp  = exp;
      if (rw && (addr == REG_CTRL)) chaos_m = wdata[0];
   endtask

   task automatic apply_row(input row_t r);
      case (r.op)
         OP_WR    : step(1'b1, r.arg, 1'b0, 1'b0, 1'b0, '0, '0, '0);
         OP_RD    : step(1'b0, '0, 1'b1, 1'b0, 1'b0, '0, '0, '0);
         OP_BOTH  : step(1'b1, r.arg, 1'b1, 1'b0, 1'b0, '0, '0, '0);
         OP_REGWR : step(1'b0, '0, 1'b0, 1'b1, 1'b0, r.addr, r.arg, '0);
         OP_REGRD : step(1'b0, '0, 1'b0, 1'b0, 1'b1, r.addr, '0, r.exp);
         OP_IDLE  : step(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
         default  :
         begin
            $display("unknown operation %0d in the stimulus table", r.op);
            other_errs++;
         end
      endcase
   endtask

   //####################################################################
   // stimulus table
   //####################################################################

   function automatic void add_row(logic [2:0] op, reg_addr_t addr, reg_data_t arg,
                                   reg_data_t exp);
      row_t r;
      r = '{op: op, addr: addr, arg: arg, exp: exp};
      stim_q.push_back(r);
   endfunction

   task automatic build_table();
      int i;
      // values out of reset
      add_row(OP_REGRD, REG_CTRL, '0, 32'd0);
      add_row(OP_REGRD, REG_SEED, '0, 32'd1);
      add_row(OP_REGRD, REG_WCOUNT, '0, 32'd0);
      add_row(OP_REGRD, REG_RCOUNT, '0, 32'd0);
      add_row(OP_REGRD, REG_DROPS, '0, 32'd0);
      add_row(OP_REGRD, REG_LEVEL, '0, 32'd0);
      // fill then one write too many
      for (i = 0; i < DEPTH; i++) add_row(OP_WR, '0, 32'hC0DE_0000 + i, '0);
      add_row(OP_WR, '0, 32'hDEAD_BEEF, '0);
      add_row(OP_REGRD, REG_DROPS, '0, 32'd1);
      add_row(OP_REGRD, REG_LEVEL, '0, DEPTH);
      // drain plus one read while empty and one idle cycle
      for (i = 0; i <= DEPTH; i++) add_row(OP_RD, '0, '0, '0);
      add_row(OP_IDLE, '0, '0, '0);
      add_row(OP_REGRD, REG_RCOUNT, '0, DEPTH);
      add_row(OP_REGRD, REG_LEVEL, '0, 32'd0);
      // read and write together at level 4
      for (i = 0; i < 4; i++) add_row(OP_WR, '0, 32'h5A00_0000 + i, '0);
      for (i = 0; i < 3; i++) add_row(OP_BOTH, '0, 32'h5A00_0010 + i, '0);
      add_row(OP_REGRD, REG_LEVEL, '0, 32'd4);
      for (i = 0; i < 3; i++) add_row(OP_BOTH, '0, 32'h5A00_0020 + i, '0);
      add_row(OP_REGRD, REG_LEVEL, '0, 32'd4);
      add_row(OP_REGRD, REG_WCOUNT, '0, DEPTH + 10);
      for (i = 0; i < 4; i++) add_row(OP_RD, '0, '0, '0);
      add_row(OP_REGRD, REG_RCOUNT, '0, DEPTH + 10);
      // zero seed becomes one before chaos goes on
      add_row(OP_REGWR, REG_SEED, 32'd0, '0);
      add_row(OP_REGRD, REG_SEED, '0, 32'd1);
      add_row(OP_REGWR, REG_SEED, 32'h0000_ACE1, '0);
      add_row(OP_REGRD, REG_SEED, '0, 32'h0000_ACE1);
      add_row(OP_REGWR, REG_CTRL, 32'd1, '0);
      add_row(OP_REGRD, REG_CTRL, '0, 32'd1);
   endtask

   //####################################################################
   // main sequence
   //####################################################################

   initial
   begin
      nreset    = 1'b0;
      wr_en     = 1'b0;
      wr_din    = '0;
      rd_en     = 1'b0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      rng_state = RNG_SEED;
      wcount_m  = '0;
      rcount_m  = '0;
      drops_m   = '0;
      chaos_m   = 1'b0;
      pend_rd   = 1'b0;
      pend_addr = '0;
      pend_exp  = '0;
      data_errs = 0;
      flag_errs = 0;
      reg_errs  = 0;
      other_errs = 0;
      last_full = 1'b0;
      build_table();
      timeout_limit = 2 * stim_q.size() + RAND_CYCLES + 100;
      repeat (2) @(negedge clk);        // two rising edges in reset
      nreset = 1'b1;
      foreach (stim_q[i]) apply_row(stim_q[i]);
      // random traffic under chaos with writes favoured
      toggles = 0;
      forced  = 0;
      repeat (RAND_CYCLES)
      begin
         logic w;
         logic r;
         w = rand_bit();
         w = w | rand_bit();
         r = rand_bit();
         step(w, rand_word(), r, 1'b0, 1'b0, '0, '0, '0);
      end
      assert ((toggles >= 10) && (forced > 0))
      else
      begin
         $display("wr_full hardly moved under chaos: %0d edges, %0d forced cycles",
                  toggles, forced);
         other_errs++;
      end
      // statistics against the model
      step(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_CTRL, '0, reg_data_t'(chaos_m));
      step(1'b0, '0, 1'b0, 1'b1, 1'b0, REG_CTRL, 32'd0, '0);
      while (ref_q.size() != 0) step(1'b0, '0, 1'b1, 1'b0, 1'b0, '0, '0, '0);
      step(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_WCOUNT, '0, wcount_m);
      step(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_RCOUNT, '0, rcount_m);
      step(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_DROPS, '0, drops_m);
      step(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_LEVEL, '0, 32'd0);
      step(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0, '0);   // last readback check
      $display("errors: %0d data, %0d flag, %0d register, %0d other",
               data_errs, flag_errs, reg_errs, other_errs);
      if ((data_errs + flag_errs + reg_errs + other_errs) == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   // run limit in clock cycles
   initial
   begin
      cycle_cnt = 0;
      @(posedge clk);
      while (cycle_cnt < timeout_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: test still running after %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
   end

endmodule
